//--- design/lg_settings.svh
/*
  width settings shared by the pattern generator RTL and its testbench
  table depth is 2**LG_TAW entries of LG_DW bits
  counter widths bound the largest burst that can be configured
*/
`ifndef LG_SETTINGS_SVH
`define LG_SETTINGS_SVH

// stream
`define LG_DW   8   // bits per stream byte

// waveform table
`define LG_TAW  10  // table address bits for 1024 entries

// burst counters
`define LG_CWR  14  // entry repetitions
`define LG_CWL  32  // beats per period
`define LG_CWN  16  // periods per burst

// register bus
`define LG_BAW  7   // decoded address bits
`define LG_TN   4   // hardware trigger inputs

`endif

//--- design/lg_pkg.sv
/*
  types of the logic pattern generator
  all widths come from lg_settings.svh
*/
`include "lg_settings.svh"

package lg_pkg;

  typedef logic [`LG_DW-1:0]  data_t;  // stream byte, also mask and enable words
  typedef logic [`LG_TAW-1:0] tadr_t;  // table address
  typedef logic [`LG_CWR-1:0] rep_t;   // entry repetition count
  typedef logic [`LG_CWL-1:0] len_t;   // beat count inside a period
  typedef logic [`LG_CWN-1:0] num_t;   // period count
  typedef logic [31:0]        word_t;  // register bus data
  typedef logic [`LG_TN-1:0]  trg_t;   // trigger inputs and their mask

  // sequencer states
  typedef enum logic [2:0] {
    IDLE,   // waiting for start
    ARMED,  // waiting for trigger
    DATA,   // sending table entries
    PAD,    // repeating the last entry to fill the period
    DONE    // final beat taken
  } burst_state_t;

endpackage

//--- design/lg_regs.sv
/*
  register file of the pattern generator
  only the low LG_BAW address bits are decoded, so the map repeats
  writes to read only or unmapped addresses are dropped, unmapped reads give zero
  the CPU must not raise wen and ren in the same cycle
*/
`timescale 1ns/1ps
`include "lg_settings.svh"

module lg_regs import lg_pkg::*; (
  input  logic  bus,
  input  logic  reset,
  // register bus
  input  word_t bus_addr,
  input  word_t bus_wdata,
  input  logic  bus_wen,
  input  logic  bus_ren,
  output word_t bus_rdata,
  output logic  bus_ack,
  // triggers and sequencer status
  input  trg_t  trg,
  input  logic  sts_armed,
  input  logic  sts_running,
  input  len_t  sts_bpl,
  input  num_t  sts_bpn,
  // event pulses to the sequencer
  output logic  evt_reset,
  output logic  evt_start,
  output logic  evt_stop,
  output logic  evt_swtrg,
  output logic  ctl_trg,
  // configuration
  output rep_t  cfg_bdr,
  output tadr_t cfg_bdl,
  output len_t  cfg_bpl,
  output num_t  cfg_bpn,
  output logic  cfg_inf,
  output data_t cfg_oen0,
  output data_t cfg_oen1,
  output data_t cfg_msk,
  output data_t cfg_val
);

  logic [`LG_BAW-1:0] adr;  // decoded part of the address
  logic               wr_ctl;
  trg_t               cfg_trg;  // trigger mask

  assign adr     = bus_addr[`LG_BAW-1:0];
  assign wr_ctl  = bus_wen && (adr == 'h00);
  assign ctl_trg = |(trg & cfg_trg);  // any enabled input fires

  //////////////////////////////////////////////////
  // bus handshake and control events

  always_ff @(posedge bus) begin
    if (reset) begin
      bus_ack   <= 1'b0;
      evt_reset <= 1'b0;
      evt_start <= 1'b0;
      evt_stop  <= 1'b0;
      evt_swtrg <= 1'b0;
    end else begin
      bus_ack   <= bus_wen | bus_ren;  // every access acked next cycle
      evt_reset <= wr_ctl & bus_wdata[0];
      evt_start <= wr_ctl & bus_wdata[1];
      evt_stop  <= wr_ctl & bus_wdata[2];
      evt_swtrg <= wr_ctl & bus_wdata[3];
    end
  end

  //////////////////////////////////////////////////
  // configuration registers

  always_ff @(posedge bus) begin
    if (reset) begin
      cfg_trg  <= '0;
      cfg_bdr  <= '0;
      cfg_bdl  <= '0;
      cfg_bpl  <= '0;
      cfg_bpn  <= '0;
      cfg_inf  <= 1'b0;
      cfg_oen0 <= '0;
      cfg_oen1 <= '0;
      cfg_msk  <= '0;
      cfg_val  <= '0;
    end else if (bus_wen) begin
      case (adr)
        'h08: cfg_trg  <= bus_wdata[`LG_TN-1:0];
        'h20: cfg_bdr  <= bus_wdata[`LG_CWR-1:0];
        'h24: cfg_bdl  <= bus_wdata[`LG_TAW-1:0];
        'h28: cfg_bpl  <= bus_wdata[`LG_CWL-1:0];
        'h2c: begin
          cfg_bpn <= bus_wdata[`LG_CWN-1:0];
          cfg_inf <= bus_wdata[31];  // endless periods
        end
        'h40: cfg_oen0 <= bus_wdata[`LG_DW-1:0];
        'h44: cfg_oen1 <= bus_wdata[`LG_DW-1:0];
        'h48: cfg_msk  <= bus_wdata[`LG_DW-1:0];
        'h4c: cfg_val  <= bus_wdata[`LG_DW-1:0];
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // readback, valid together with ack

  always_ff @(posedge bus) begin
    if (bus_ren) begin
      case (adr)
        'h00: bus_rdata <= {30'd0, sts_running, sts_armed};
        'h08: bus_rdata <= word_t'(cfg_trg);
        'h20: bus_rdata <= word_t'(cfg_bdr);
        'h24: bus_rdata <= word_t'(cfg_bdl);
        'h28: bus_rdata <= word_t'(cfg_bpl);
        'h2c: bus_rdata <= {cfg_inf, 31'(cfg_bpn)};
        'h30: bus_rdata <= word_t'(sts_bpl);  // beats in current period
        'h34: bus_rdata <= word_t'(sts_bpn);  // completed periods
        'h40: bus_rdata <= word_t'(cfg_oen0);
        'h44: bus_rdata <= word_t'(cfg_oen1);
        'h48: bus_rdata <= word_t'(cfg_msk);
        'h4c: bus_rdata <= word_t'(cfg_val);
        default: bus_rdata <= '0;
      endcase
    end
  end

  // the CPU side never issues a read and a write together
  a_bus_excl: assert property (@(posedge bus) disable iff (reset) !(bus_wen && bus_ren));

endmodule

//--- design/lg_table.sv
/*
  waveform table, one LG_DW bit entry per 32-bit word address
  entry index is tbl_addr[LG_TAW+1:2], upper address bits are ignored
  CPU writes and sequencer reads of one entry in the same cycle return old data
*/
`timescale 1ns/1ps
`include "lg_settings.svh"

module lg_table import lg_pkg::*; (
  input  logic  bus,
  // CPU port
  input  word_t tbl_addr,
  input  word_t tbl_wdata,
  input  logic  tbl_wen,
  input  logic  tbl_ren,
  output word_t tbl_rdata,
  output logic  tbl_ack,
  // sequencer port
  input  tadr_t rd_addr,
  output data_t rd_data
);

  data_t mem [0:2**`LG_TAW-1];  // table storage
  tadr_t cpu_adr;

  assign cpu_adr = tbl_addr[`LG_TAW+1:2];  // word aligned entries

  // ack one cycle after any access
  always_ff @(posedge bus) begin
    tbl_ack <= tbl_wen | tbl_ren;
  end

  //////////////////////////////////////////////////
  // CPU side

  always_ff @(posedge bus) begin
    if (tbl_wen) begin
      mem[cpu_adr] <= tbl_wdata[`LG_DW-1:0];  // upper bits dropped
    end
    if (tbl_ren) begin
      tbl_rdata <= word_t'(mem[cpu_adr]);
    end
  end

  //////////////////////////////////////////////////
  // sequencer side

  // read every cycle, data one cycle after the address
  always_ff @(posedge bus) begin
    rd_data <= mem[rd_addr];
  end

endmodule

//--- design/lg_burst.sv
/*
  burst sequencer, reads the table out as a valid/ready/last byte stream
  rd_addr is combinational and depends on stg_ready
  tro and irq are registered and appear one cycle after the beat they mark
  sts_bpl and sts_bpn wrap in infinite mode
*/
`timescale 1ns/1ps

module lg_burst import lg_pkg::*; (
  input  logic  bus,
  input  logic  reset,
  // events and trigger
  input  logic  evt_reset,
  input  logic  evt_start,
  input  logic  evt_stop,
  input  logic  evt_swtrg,
  input  logic  ctl_trg,
  // burst configuration
  input  rep_t  cfg_bdr,
  input  tadr_t cfg_bdl,
  input  len_t  cfg_bpl,
  input  num_t  cfg_bpn,
  input  logic  cfg_inf,
  // table read port
  output tadr_t rd_addr,
  input  data_t rd_data,
  // stream
  output data_t stg_data,
  output logic  stg_valid,
  output logic  stg_last,
  input  logic  stg_ready,
  // period and end pulses, status
  output logic  tro,
  output logic  irq,
  output logic  sts_armed,
  output logic  sts_running,
  output len_t  sts_bpl,
  output num_t  sts_bpn
);

  burst_state_t state;

  // fetch position, the beat that loads next into the output register
  rep_t  f_rep;
  tadr_t f_ent;
  len_t  f_bpl;
  num_t  f_bpn;

  rep_t  nxt_rep;
  tadr_t nxt_ent;
  logic  nxt_pad;   // fetch moves into padding
  logic  f_eop;     // fetch beat closes its period
  logic  f_end;     // fetch beat is the final one
  logic  stg_eop;   // output beat closes its period
  logic  xfer;
  logic  ld;
  logic  trig;

  assign trig  = ctl_trg | evt_swtrg;
  assign xfer  = stg_valid & stg_ready;
  assign f_eop = (f_bpl == cfg_bpl);  // also cuts data longer than the period
  assign f_end = f_eop & (f_bpn == cfg_bpn) & ~cfg_inf;

  // output register free or emptied this cycle, nothing after a last beat
  assign ld = ((state == DATA) || (state == PAD)) && !(stg_valid && stg_last)
           && (!stg_valid || stg_ready);

  assign sts_armed   = (state == ARMED);
  assign sts_running = (state == DATA) || (state == PAD);

  //////////////////////////////////////////////////
  // next fetch position

  always_comb begin
    nxt_rep = f_rep;
    nxt_ent = f_ent;
    nxt_pad = (state == PAD);
    if (f_eop) begin
      nxt_rep = '0;  // new period from entry 0
      nxt_ent = '0;
      nxt_pad = 1'b0;
    end else if (state == DATA) begin
      if (f_rep == cfg_bdr) begin
        nxt_rep = '0;
        if (f_ent == cfg_bdl) begin
          nxt_pad = 1'b1;  // keep repeating entry bdl
        end else begin
          nxt_ent = f_ent + 1'b1;
        end
      end else begin
        nxt_rep = f_rep + 1'b1;
      end
    end
  end

  // prefetch, table data is ready when the output register takes it
  assign rd_addr = ld ? nxt_ent : f_ent;

  //////////////////////////////////////////////////
  // state machine and counters

  always_ff @(posedge bus) begin
    if (reset) begin
      state     <= IDLE;
      f_rep     <= '0;
      f_ent     <= '0;
      f_bpl     <= '0;
      f_bpn     <= '0;
      stg_valid <= 1'b0;
      stg_last  <= 1'b0;
      stg_eop   <= 1'b0;
      tro       <= 1'b0;
      irq       <= 1'b0;
      sts_bpl   <= '0;
      sts_bpn   <= '0;
    end else begin
      tro <= xfer & (sts_bpl == '0);  // first beat of a period
      irq <= xfer & stg_last;
      if (xfer) begin
        sts_bpl <= stg_eop ? '0 : sts_bpl + 1'b1;
        sts_bpn <= sts_bpn + stg_eop;
      end
      if (evt_stop || evt_reset) begin
        state     <= IDLE;  // abort, beat in flight is dropped
        stg_valid <= 1'b0;
        stg_last  <= 1'b0;
        if (evt_reset) begin
          sts_bpl <= '0;
          sts_bpn <= '0;
        end
      end else begin
        case (state)
          IDLE: begin
            f_rep <= '0;
            f_ent <= '0;  // table entry 0 is read while armed
            f_bpl <= '0;
            f_bpn <= '0;
            if (evt_start) begin
              state <= ARMED;
            end
          end
          ARMED: begin
            if (trig) begin
              state   <= DATA;
              sts_bpl <= '0;
              sts_bpn <= '0;
            end
          end
          DATA, PAD: begin
            if (ld) begin
              f_rep     <= nxt_rep;
              f_ent     <= nxt_ent;
              f_bpl     <= f_eop ? '0 : f_bpl + 1'b1;
              f_bpn     <= f_bpn + f_eop;
              state     <= nxt_pad ? PAD : DATA;
              stg_valid <= 1'b1;
              stg_last  <= f_end;
              stg_eop   <= f_eop;
            end else if (xfer) begin
              stg_valid <= 1'b0;  // final beat taken
              stg_last  <= 1'b0;
              state     <= DONE;
            end
          end
          DONE: state <= IDLE;
          default: state <= IDLE;
        endcase
      end
    end
  end

  // output data register
  always_ff @(posedge bus) begin
    if (ld) begin
      stg_data <= rd_data;
    end
  end

  // stalled beat keeps its content until taken or aborted
  a_hold: assert property (@(posedge bus) disable iff (reset)
    stg_valid && !stg_ready && !evt_stop && !evt_reset
    |=> stg_valid && $stable(stg_data) && $stable(stg_last));

  a_last: assert property (@(posedge bus) disable iff (reset) stg_last |-> stg_valid);

endmodule

//--- design/lg_output.sv
/*
  output stage on the stream data, purely combinational
  a set mask bit replaces the data bit by the polarity bit
  valid, last and ready bypass this stage
*/
`timescale 1ns/1ps

module lg_output import lg_pkg::*; (
  input  data_t stg_data,
  input  data_t cfg_msk,
  input  data_t cfg_val,
  input  data_t cfg_oen0,
  input  data_t cfg_oen1,
  output data_t sto_data,
  output data_t sto_oe
);

  data_t dat_msk;  // data with masked bits cleared

  //////////////////////////////////////////////////
  // data path

  assign dat_msk  = stg_data & ~cfg_msk;
  assign sto_data = cfg_val ^ dat_msk;  // polarity flip

  //////////////////////////////////////////////////
  // output enable

  // per bit, oen0 drives a low output and oen1 a high one
  assign sto_oe = (cfg_oen0 & ~sto_data)
                | (cfg_oen1 &  sto_data);

endmodule

//--- design/lg_top.sv
/*
  single channel logic pattern generator
  one clock, synchronous active high reset
  register and table buses share the one-cycle ack handshake
*/
`timescale 1ns/1ps

module lg_top import lg_pkg::*; (
  input  logic  bus,
  input  logic  reset,
  input  trg_t  trg,
  // register bus
  input  word_t bus_addr,
  input  word_t bus_wdata,
  input  logic  bus_wen,
  input  logic  bus_ren,
  output word_t bus_rdata,
  output logic  bus_ack,
  // table bus
  input  word_t tbl_addr,
  input  word_t tbl_wdata,
  input  logic  tbl_wen,
  input  logic  tbl_ren,
  output word_t tbl_rdata,
  output logic  tbl_ack,
  // output stream
  output data_t sto_data,
  output data_t sto_oe,
  output logic  sto_valid,
  output logic  sto_last,
  input  logic  sto_ready,
  // events
  output logic  tro,
  output logic  irq
);

  logic  evt_reset;
  logic  evt_start;
  logic  evt_stop;
  logic  evt_swtrg;
  logic  ctl_trg;
  rep_t  cfg_bdr;
  tadr_t cfg_bdl;
  len_t  cfg_bpl;
  num_t  cfg_bpn;
  logic  cfg_inf;
  data_t cfg_oen0;
  data_t cfg_oen1;
  data_t cfg_msk;
  data_t cfg_val;
  logic  sts_armed;
  logic  sts_running;
  len_t  sts_bpl;
  num_t  sts_bpn;
  tadr_t rd_addr;
  data_t rd_data;
  data_t stg_data;  // raw table byte before the output stage

  //////////////////////////////////////////////////
  // registers and table

  lg_regs u_regs (
    .bus         (bus),
    .reset       (reset),
    .bus_addr    (bus_addr),
    .bus_wdata   (bus_wdata),
    .bus_wen     (bus_wen),
    .bus_ren     (bus_ren),
    .bus_rdata   (bus_rdata),
    .bus_ack     (bus_ack),
    .trg         (trg),
    .sts_armed   (sts_armed),
    .sts_running (sts_running),
    .sts_bpl     (sts_bpl),
    .sts_bpn     (sts_bpn),
    .evt_reset   (evt_reset),
    .evt_start   (evt_start),
    .evt_stop    (evt_stop),
    .evt_swtrg   (evt_swtrg),
    .ctl_trg     (ctl_trg),
    .cfg_bdr     (cfg_bdr),
    .cfg_bdl     (cfg_bdl),
    .cfg_bpl     (cfg_bpl),
    .cfg_bpn     (cfg_bpn),
    .cfg_inf     (cfg_inf),
    .cfg_oen0    (cfg_oen0),
    .cfg_oen1    (cfg_oen1),
    .cfg_msk     (cfg_msk),
    .cfg_val     (cfg_val)
  );

  lg_table u_table (
    .bus       (bus),
    .tbl_addr  (tbl_addr),
    .tbl_wdata (tbl_wdata),
    .tbl_wen   (tbl_wen),
    .tbl_ren   (tbl_ren),
    .tbl_rdata (tbl_rdata),
    .tbl_ack   (tbl_ack),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  //////////////////////////////////////////////////
  // sequencer and output stage

  // valid, last and ready go straight to the top ports
  lg_burst u_burst (
    .bus         (bus),
    .reset       (reset),
    .evt_reset   (evt_reset),
    .evt_start   (evt_start),
    .evt_stop    (evt_stop),
    .evt_swtrg   (evt_swtrg),
    .ctl_trg     (ctl_trg),
    .cfg_bdr     (cfg_bdr),
    .cfg_bdl     (cfg_bdl),
    .cfg_bpl     (cfg_bpl),
    .cfg_bpn     (cfg_bpn),
    .cfg_inf     (cfg_inf),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .stg_data    (stg_data),
    .stg_valid   (sto_valid),
    .stg_last    (sto_last),
    .stg_ready   (sto_ready),
    .tro         (tro),
    .irq         (irq),
    .sts_armed   (sts_armed),
    .sts_running (sts_running),
    .sts_bpl     (sts_bpl),
    .sts_bpn     (sts_bpn)
  );

  lg_output u_output (
    .stg_data (stg_data),
    .cfg_msk  (cfg_msk),
    .cfg_val  (cfg_val),
    .cfg_oen0 (cfg_oen0),
    .cfg_oen1 (cfg_oen1),
    .sto_data (sto_data),
    .sto_oe   (sto_oe)
  );

endmodule

//--- verif/lg_tb.sv
/*
  testbench of lg_top, the checks are assertions on every transferred beat
  table model covers entries 0..63 only, bursts stay inside them
  expected bytes come from a reference queue built from the burst rules
*/
`timescale 1ns/1ps
`include "lg_settings.svh"

module lg_tb import lg_pkg::*; ();

  // longest burst ~200 beats, doubled by stalls, six tests plus bus traffic
  localparam int TIMEOUT = 20000;
  localparam int TBL_N   = 64;  // table entries used

  logic  bus;
  logic  reset;
  trg_t  trg;
  word_t bus_addr;
  word_t bus_wdata;
  logic  bus_wen;
  logic  bus_ren;
  word_t bus_rdata;
  logic  bus_ack;
  word_t tbl_addr;
  word_t tbl_wdata;
  logic  tbl_wen;
  logic  tbl_ren;
  word_t tbl_rdata;
  logic  tbl_ack;
  data_t sto_data;
  data_t sto_oe;
  logic  sto_valid;
  logic  sto_last;
  logic  sto_ready;
  logic  tro;
  logic  irq;

  data_t      tbl_model [0:TBL_N-1];
  logic [8:0] exp_q [$];  // {last, byte}
  data_t      exp_raw;
  logic       exp_last;
  logic       exp_empty;
  data_t      exp_out;
  data_t      exp_oe;
  data_t      t_msk;  // copies of the output stage registers
  data_t      t_val;
  data_t      t_oen0;
  data_t      t_oen1;
  logic       stall;
  logic       hold_en;
  int         cycles;
  int         beats;
  int         tro_n;
  int         irq_n;
  int         errors;
  int         tests;
  int         failed;
  int         bdr;
  int         bdl;
  int         bpl;
  int         bpn;

  lg_top lg_top_inst (.*);

  // masked bit gives the polarity bit, else polarity flips the data bit
  function automatic data_t apply_mask_polarity(input data_t d, input data_t m, input data_t v);
    data_t o;
    for (int i = 0; i < `LG_DW; i++) begin
      o[i] = m[i] ? v[i] : (v[i] ^ d[i]);
    end
    return o;
  endfunction

  // enable bit picked by the level of the output bit
  function automatic data_t select_enable(input data_t o, input data_t e0, input data_t e1);
    data_t oe;
    for (int i = 0; i < `LG_DW; i++) begin
      oe[i] = o[i] ? e1[i] : e0[i];
    end
    return oe;
  endfunction

  assign exp_out = apply_mask_polarity(exp_raw, t_msk, t_val);
  assign exp_oe  = select_enable(exp_out, t_oen0, t_oen1);

  initial begin
    bus = 1'b0;
    forever #10 bus = ~bus;
  end

  //////////////////////////////////////////////////
  // stream side, ready driver and beat bookkeeping

  always @(posedge bus) begin
    sto_ready <= stall ? 1'($urandom % 2) : 1'b1;  // random back-pressure
  end

  always @(posedge bus) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("timeout after %0d cycles, the stream never finished", cycles);
      $display("TEST FAILED");
      $finish;
    end else if (!reset) begin
      if (tro) tro_n++;
      if (irq) irq_n++;
      if (sto_valid && sto_ready) begin
        beats++;
        if (exp_q.size() > 0) void'(exp_q.pop_front());
        refresh_head();
      end
    end
  end

  task automatic refresh_head();
    exp_empty = (exp_q.size() == 0);
    exp_raw   = exp_empty ? '0 : exp_q[0][7:0];
    exp_last  = exp_empty ? 1'b0 : exp_q[0][8];
  endtask

  //////////////////////////////////////////////////
  // assertions

  a_beat_expected: assert property (@(posedge bus) disable iff (reset)
    sto_valid && sto_ready |-> !exp_empty)
    else begin
      $display("beat at %0t was not expected, stream too long", $time);
      errors++;
    end

  a_beat_data: assert property (@(posedge bus) disable iff (reset)
    sto_valid && sto_ready && !exp_empty |-> sto_data == exp_out)
    else begin
      $display("FAIL %0t: data %h expected %h", $time, $sampled(sto_data), $sampled(exp_out));
      errors++;
    end

  a_beat_oe: assert property (@(posedge bus) disable iff (reset)
    sto_valid && sto_ready && !exp_empty |-> sto_oe == exp_oe)
    else begin
      $display("FAIL %0t: oe %h expected %h", $time, $sampled(sto_oe), $sampled(exp_oe));
      errors++;
    end

  a_beat_last: assert property (@(posedge bus) disable iff (reset)
    sto_valid && sto_ready && !exp_empty |-> sto_last == exp_last)
    else begin
      $display("FAIL %0t: last %b expected %b", $time, $sampled(sto_last), $sampled(exp_last));
      errors++;
    end

  a_hold: assert property (@(posedge bus) disable iff (reset)
    sto_valid && !sto_ready && hold_en |=> sto_valid && $stable(sto_data) && $stable(sto_last))
    else begin
      $display("FAIL %0t: stalled beat changed", $time);
      errors++;
    end

  a_reg_ack: assert property (@(posedge bus) disable iff (reset)
    bus_ack == $past(bus_wen || bus_ren))
    else begin
      $display("FAIL %0t: register ack %b off by a cycle", $time, $sampled(bus_ack));
      errors++;
    end

  a_tbl_ack: assert property (@(posedge bus) disable iff (reset)
    tbl_ack == $past(tbl_wen || tbl_ren))
    else begin
      $display("FAIL %0t: table ack %b off by a cycle", $time, $sampled(tbl_ack));
      errors++;
    end

  //////////////////////////////////////////////////
  // bus tasks

  // ack and rdata sampled at the falling edge
  task automatic wait_ack(input bit tbl, output word_t rd);
    int n;
    n  = 0;
    rd = '0;
    do begin
      @(negedge bus);
      n++;
    end while (!(tbl ? tbl_ack : bus_ack) && n < 4);
    if (tbl ? tbl_ack : bus_ack) begin
      rd = tbl ? tbl_rdata : bus_rdata;
    end else begin
      $display("no acknowledge on the %s bus at %0t", tbl ? "table" : "register", $time);
      errors++;
    end
  endtask

  task automatic reg_write(input int adr, input word_t d);
    word_t rd;
    @(posedge bus);
    bus_addr  <= adr;
    bus_wdata <= d;
    bus_wen   <= 1'b1;
    @(posedge bus);
    bus_wen   <= 1'b0;
    wait_ack(1'b0, rd);
  endtask

  task automatic reg_read(input int adr, output word_t rd);
    @(posedge bus);
    bus_addr <= adr;
    bus_ren  <= 1'b1;
    @(posedge bus);
    bus_ren  <= 1'b0;
    wait_ack(1'b0, rd);
  endtask

  task automatic tbl_write(input int idx, input word_t d);
    word_t rd;
    @(posedge bus);
    tbl_addr  <= idx * 4;
    tbl_wdata <= d;
    tbl_wen   <= 1'b1;
    @(posedge bus);
    tbl_wen   <= 1'b0;
    wait_ack(1'b1, rd);
  endtask

  task automatic tbl_check(input int idx);
    word_t rd;
    @(posedge bus);
    tbl_addr <= idx * 4;
    tbl_ren  <= 1'b1;
    @(posedge bus);
    tbl_ren  <= 1'b0;
    wait_ack(1'b1, rd);
    assert (rd == word_t'(tbl_model[idx])) else begin
      $display("FAIL %0t: table entry %0d read %h expected %h", $time, idx, rd, tbl_model[idx]);
      errors++;
    end
  endtask

  task automatic reg_check(input int adr, input word_t exp);
    word_t rd;
    reg_read(adr, rd);
    assert (rd == exp) else begin
      $display("FAIL %0t: reg %h read %h expected %h", $time, adr, rd, exp);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // burst helpers

  // each entry bdr+1 times, then pad with entry bdl, period cut at bpl+1
  task automatic build_expected(input int periods, input bit with_last);
    int n;
    int ent;
    for (int p = 0; p < periods; p++) begin
      for (int b = 0; b <= bpl; b++) begin
        n   = b / (bdr + 1);
        ent = (n > bdl) ? bdl : n;
        exp_q.push_back({with_last && p == periods - 1 && b == bpl, tbl_model[ent]});
      end
    end
    refresh_head();
  endtask

  task automatic random_burst();
    bdr = $urandom_range(2, 0);
    bdl = $urandom_range(15, 0);
    bpl = $urandom_range(40, 0);
    bpn = $urandom_range(3, 0);
  endtask

  task automatic set_burst(input bit inf);
    reg_write('h20, bdr);
    reg_write('h24, bdl);
    reg_write('h28, bpl);
    reg_write('h2c, {inf, 31'(bpn)});
  endtask

  task automatic set_output(input data_t m, input data_t v, input data_t o0, input data_t o1);
    t_msk  = m;
    t_val  = v;
    t_oen0 = o0;
    t_oen1 = o1;
    reg_write('h48, m);
    reg_write('h4c, v);
    reg_write('h40, o0);
    reg_write('h44, o1);
  endtask

  task automatic clear_counts();
    @(negedge bus);
    beats = 0;
    tro_n = 0;
    irq_n = 0;
  endtask

  // wait for the queue to drain and irq, bounded per burst
  task automatic wait_done();
    int n;
    n = 0;
    while ((exp_q.size() > 0 || irq_n == 0) && n < 2000) begin
      @(negedge bus);
      n++;
    end
    if (n >= 2000) begin
      $display("burst did not complete, %0d beats still pending", exp_q.size());
      errors++;
    end
    repeat (3) @(negedge bus);  // let late pulses arrive
  endtask

  task automatic check_pulses();
    assert (tro_n == bpn + 1 && irq_n == 1) else begin
      $display("FAIL %0t: tro %0d irq %0d expected %0d and 1", $time, tro_n, irq_n, bpn + 1);
      errors++;
    end
  endtask

  // single burst started by a software trigger
  task automatic sw_burst();
    clear_counts();
    set_burst(1'b0);
    build_expected(bpn + 1, 1'b1);
    reg_write('h00, 2);  // start
    reg_write('h00, 8);  // software trigger
    wait_done();
    check_pulses();
  endtask

  task automatic report(input string name, input int err_start);
    tests++;
    if (errors == err_start) begin
      $display("test %0d %s: pass", tests, name);
    end else begin
      failed++;
      $display("test %0d %s: fail", tests, name);
    end
  endtask

  //////////////////////////////////////////////////
  // test sequence

  initial begin
    int e;
    void'($urandom(32'h8a2b));
    reset     = 1'b1;
    trg       = '0;
    bus_addr  = '0;
    bus_wdata = '0;
    bus_wen   = 1'b0;
    bus_ren   = 1'b0;
    tbl_addr  = '0;
    tbl_wdata = '0;
    tbl_wen   = 1'b0;
    tbl_ren   = 1'b0;
    sto_ready = 1'b0;
    stall     = 1'b0;
    hold_en   = 1'b1;
    t_msk     = '0;
    t_val     = '0;
    t_oen0    = '0;
    t_oen1    = '0;
    cycles    = 0;
    errors    = 0;
    tests     = 0;
    failed    = 0;
    refresh_head();
    repeat (10) @(posedge bus);
    reset <= 1'b0;

    // 1 register and table access
    e = errors;
    for (int i = 0; i < TBL_N; i++) begin
      tbl_model[i] = data_t'($urandom);
      tbl_write(i, {24'hA5A5A5, tbl_model[i]});  // upper bits dropped
    end
    for (int i = 0; i < 8; i++) tbl_check($urandom_range(TBL_N - 1, 0));
    reg_write('h08, 'hA);
    reg_check('h08, 'hA);
    reg_write('h20, 'h1234);
    reg_check('h20, 'h1234);
    reg_write('h24, 'h2A5);
    reg_check('h24, 'h2A5);
    reg_write('h28, 'hDEAD_BEEF);
    reg_check('h28, 'hDEAD_BEEF);
    reg_write('h2c, 'h8000_5A5A);
    reg_check('h2c, 'h8000_5A5A);  // infinite flag in bit 31
    for (int a = 'h40; a <= 'h4c; a += 4) begin
      reg_write(a, a + 'h11);
      reg_check(a, a + 'h11);
    end
    set_output('0, '0, '0, '0);
    report("register access", e);

    // 2 burst content, ready high
    e = errors;
    random_burst();
    sw_burst();
    report("burst content", e);

    // 3 same burst under back-pressure
    e = errors;
    stall = 1'b1;
    sw_burst();
    stall = 1'b0;
    report("back-pressure", e);

    // 4 trigger gating
    e = errors;
    random_burst();
    clear_counts();
    reg_write('h08, 'b0100);  // only input 2 enabled
    set_burst(1'b0);
    build_expected(bpn + 1, 1'b1);
    reg_write('h00, 2);
    @(posedge bus);
    trg <= 'b1011;  // masked-off inputs
    repeat (5) @(posedge bus);
    trg <= '0;
    reg_check('h00, 1);  // still armed
    assert (beats == 0) else begin
      $display("masked trigger started the burst at %0t", $time);
      errors++;
    end
    @(posedge bus);
    trg <= 'b0100;
    @(posedge bus);
    trg <= '0;
    wait_done();
    check_pulses();
    report("trigger gating", e);

    // 5 output stage with random mask, polarity and enables
    e = errors;
    set_output(data_t'($urandom), data_t'($urandom), data_t'($urandom), data_t'($urandom));
    random_burst();
    stall = 1'b1;
    sw_burst();
    stall = 1'b0;
    report("output stage", e);

    // 6 infinite mode, then stop
    e = errors;
    bdr = 0;
    bdl = 5;
    bpl = 7;
    bpn = 1;
    clear_counts();
    set_burst(1'b1);
    build_expected(12, 1'b0);  // no last anywhere
    reg_write('h00, 2);
    reg_write('h00, 8);
    for (int n = 0; n < 400 && tro_n < bpn + 3; n++) @(negedge bus);
    hold_en = 1'b0;  // stop may cut a stalled beat
    reg_write('h00, 4);
    repeat (3) @(negedge bus);
    assert (!sto_valid && tro_n >= bpn + 3 && irq_n == 0) else begin
      $display("FAIL %0t: valid %b tro %0d irq %0d after stop", $time, sto_valid, tro_n, irq_n);
      errors++;
    end
    reg_check('h00, 0);  // idle
    exp_q.delete();
    refresh_head();
    hold_en = 1'b1;
    report("stop and infinite mode", e);

    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (failed == 0 && errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+design
design/lg_pkg.sv
design/lg_regs.sv
design/lg_table.sv
design/lg_burst.sv
design/lg_output.sv
design/lg_top.sv
verif/lg_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the pattern generator testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f --top-module lg_tb -o lg_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/lg_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi
exit 0
